//--- source/texel_pkg.sv
// ----------------------------------------------------------
// texel package
// texture geometry, texel and filtered sample types
// ----------------------------------------------------------

package texel_pkg;

	// texture is 16 x 16 texels
	localparam int TEX_ADDR_BITS = 4;
	localparam int COMPONENTS    = 3;
	localparam int COMP_BITS     = 8;

	typedef logic [COMP_BITS-1:0] component_t;

	typedef struct packed {
		component_t r;
		component_t g;
		component_t b;
	} texel_t;

	typedef struct packed {
		logic [TEX_ADDR_BITS-1:0] x;
		logic [TEX_ADDR_BITS-1:0] y;
	} tex_addr_t;

	// border is set when all four taps missed the texture
	typedef struct packed {
		logic   border;
		texel_t texel;
	} sample_t;

endpackage

//--- source/sampler_pkg.sv
// ----------------------------------------------------------
// sampler package
// coordinates, tap weights, tap phase and memory request types
// ----------------------------------------------------------

package sampler_pkg;

	// integer part 16..31 lies outside the texture
	localparam int INT_BITS  = 5;
	localparam int FRAC_BITS = 4;

	typedef struct packed {
		logic [INT_BITS-1:0]  x_int;
		logic [FRAC_BITS-1:0] x_frac;
		logic [INT_BITS-1:0]  y_int;
		logic [FRAC_BITS-1:0] y_frac;
	} coord_t;

	// unsigned 1.8 fixed point, 0..256
	typedef logic [2*FRAC_BITS:0] weight_t;

	// first digit is x offset, second is y offset
	typedef enum logic [1:0] {
		TAP_00,
		TAP_10,
		TAP_01,
		TAP_11
	} tap_phase_t;

	typedef struct packed {
		logic [INT_BITS-1:0] x;
		logic [INT_BITS-1:0] y;
		weight_t             weight;
	} mem_req_t;

	// weight rides along with the read so the unit needs no tap queue
	typedef struct packed {
		texel_pkg::texel_t texel;
		logic              border;
		weight_t           weight;
	} mem_rsp_t;

endpackage

//--- source/bilinear_unit.sv
// ----------------------------------------------------------
// bilinear sampling unit
// four taps per coordinate, weighted accumulation, credit flow
// ----------------------------------------------------------

module bilinear_unit #(
	parameter int CREDITS = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  coord_valid,
	input  sampler_pkg::coord_t   coord,
	output logic                  coord_ready,
	output logic                  req_valid,
	output sampler_pkg::mem_req_t req,
	input  logic                  grant,
	input  logic                  rsp_valid,
	input  sampler_pkg::mem_rsp_t rsp,
	output logic                  sample_valid,
	output texel_pkg::sample_t    sample,
	input  logic                  credit_return
);
	import texel_pkg::*;
	import sampler_pkg::*;

	localparam int      CNT_BITS    = $clog2(CREDITS + 1);
	localparam int      SUM_BITS    = COMP_BITS + 2 * FRAC_BITS + 1;
	localparam weight_t UNIT_WEIGHT = weight_t'(1 << FRAC_BITS);

	logic                        busy;
	tap_phase_t                  phase;
	coord_t                      held;
	logic [CNT_BITS-1:0]         credits;
	logic                        accept;
	logic                        x_step;
	logic                        y_step;
	weight_t                     x_factor;
	weight_t                     y_factor;
	component_t [COMPONENTS-1:0] rsp_comp;
	logic [SUM_BITS-1:0]         sums [COMPONENTS];
	logic [1:0]                  rsp_count;
	logic                        border_all;
	logic                        acc_done;
	component_t [COMPONENTS-1:0] out_comp;
	logic                        out_border;

	// stepping past 31 must stay outside the texture
	function automatic logic [INT_BITS-1:0] tap_addr(logic [INT_BITS-1:0] base, logic step);
		logic [INT_BITS:0] next;
		next = {1'b0, base} + {{INT_BITS{1'b0}}, step};
		tap_addr = next[INT_BITS] ? '1 : next[INT_BITS-1:0];
	endfunction

	// ----------------------------------------------------------
	// tap generator
	// ----------------------------------------------------------
	assign coord_ready = !busy && (credits != '0);
	assign accept      = coord_valid && coord_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			phase <= TAP_00;
		end else if (accept) begin
			busy  <= 1'b1;
			phase <= TAP_00;
		end else if (busy && grant) begin
			case (phase)
			TAP_00: phase <= TAP_10;
			TAP_10: phase <= TAP_01;
			TAP_01: phase <= TAP_11;
			default: begin
				phase <= TAP_00;
				busy  <= 1'b0;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= coord;
	end

	assign x_step = (phase == TAP_10) || (phase == TAP_11);
	assign y_step = (phase == TAP_01) || (phase == TAP_11);

	// far tap gets frac, near tap gets 1 - frac
	assign x_factor = x_step ? weight_t'(held.x_frac) : UNIT_WEIGHT - weight_t'(held.x_frac);
	assign y_factor = y_step ? weight_t'(held.y_frac) : UNIT_WEIGHT - weight_t'(held.y_frac);

	assign req_valid = busy;
	assign req = '{
		x:      tap_addr(held.x_int, x_step),
		y:      tap_addr(held.y_int, y_step),
		weight: x_factor * y_factor
	};

	// ----------------------------------------------------------
	// credits
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			credits <= CNT_BITS'(CREDITS);
		else if (accept && !credit_return)
			credits <= credits - 1'b1;
		else if (!accept && credit_return)
			credits <= credits + 1'b1;
	end

	// ----------------------------------------------------------
	// accumulator
	// ----------------------------------------------------------
	assign rsp_comp = rsp.texel;

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_count <= '0;
			acc_done  <= 1'b0;
		end else begin
			acc_done <= rsp_valid && (rsp_count == 2'd3);
			if (rsp_valid)
				rsp_count <= rsp_count + 2'd1;
		end
	end

	// first tap loads, the rest add
	always_ff @(posedge clk) begin
		if (rsp_valid) begin
			for (int c = 0; c < COMPONENTS; c++) begin
				if (rsp_count == 2'd0)
					sums[c] <= rsp.weight * rsp_comp[c];
				else
					sums[c] <= sums[c] + rsp.weight * rsp_comp[c];
			end
			border_all <= (rsp_count == 2'd0) ? rsp.border : (border_all & rsp.border);
		end
	end

	// sample register, sum >> 8
	always_ff @(posedge clk) begin
		if (acc_done) begin
			for (int c = 0; c < COMPONENTS; c++)
				out_comp[c] <= sums[c][2*FRAC_BITS +: COMP_BITS];
			out_border <= border_all;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			sample_valid <= 1'b0;
		else
			sample_valid <= acc_done;
	end

	assign sample = '{border: out_border, texel: texel_t'(out_comp)};

endmodule

//--- source/texel_arbiter.sv
// ----------------------------------------------------------
// round-robin texel read arbiter
// one grant per cycle, responses steered back by port
// ----------------------------------------------------------

module texel_arbiter #(
	parameter int NUM_PORTS = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [NUM_PORTS-1:0]  req_valid,
	input  sampler_pkg::mem_req_t req [NUM_PORTS],
	output logic [NUM_PORTS-1:0]  grant,
	output logic [NUM_PORTS-1:0]  rsp_valid,
	output sampler_pkg::mem_rsp_t rsp,
	output logic                  mem_req_valid,
	output sampler_pkg::mem_req_t mem_req,
	input  sampler_pkg::mem_rsp_t mem_rsp
);
	localparam int IDX_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [IDX_BITS-1:0]  last;
	logic [IDX_BITS-1:0]  pick;
	logic                 found;
	logic [NUM_PORTS-1:0] pending;

	// search starts one past the last granted port
	always_comb begin
		pick  = last;
		found = 1'b0;
		for (int i = 1; i <= NUM_PORTS; i++) begin
			int cand;
			cand = (int'(last) + i) % NUM_PORTS;
			if (!found && req_valid[cand]) begin
				found = 1'b1;
				pick  = IDX_BITS'(cand);
			end
		end
	end

	assign grant         = found ? (NUM_PORTS'(1) << pick) : '0;
	assign mem_req_valid = found;
	assign mem_req       = req[pick];

	// memory answers one cycle later, remember who asked
	always_ff @(posedge clk) begin
		if (reset) begin
			last    <= IDX_BITS'(NUM_PORTS - 1);
			pending <= '0;
		end else begin
			pending <= grant;
			if (found)
				last <= pick;
		end
	end

	assign rsp_valid = pending;
	assign rsp       = mem_rsp;

endmodule

//--- source/texture_memory.sv
// ----------------------------------------------------------
// texture memory
// 16 x 16 texels, one-cycle read, border on out-of-range taps
// ----------------------------------------------------------

module texture_memory (
	input  logic                  clk,
	input  logic                  wr_en,
	input  texel_pkg::tex_addr_t  wr_addr,
	input  texel_pkg::texel_t     wr_texel,
	input  logic                  mem_req_valid,
	input  sampler_pkg::mem_req_t mem_req,
	output sampler_pkg::mem_rsp_t mem_rsp
);
	import texel_pkg::*;
	import sampler_pkg::*;

	localparam int DEPTH = 2 ** (2 * TEX_ADDR_BITS);

	texel_t    mem [DEPTH];
	tex_addr_t rd_addr;
	logic      outside;

	// load port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_texel;
	end

	// top integer bit set on either axis means off the texture
	assign outside = mem_req.x[INT_BITS-1] | mem_req.y[INT_BITS-1];
	assign rd_addr = '{
		x: mem_req.x[TEX_ADDR_BITS-1:0],
		y: mem_req.y[TEX_ADDR_BITS-1:0]
	};

	// ----------------------------------------------------------
	// registered read
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mem_req_valid) begin
			mem_rsp.texel  <= outside ? texel_t'('0) : mem[rd_addr];
			mem_rsp.border <= outside;
			mem_rsp.weight <= mem_req.weight;
		end
	end

endmodule

//--- source/texture_sampler.sv
// ----------------------------------------------------------
// texture sampler top
// bilinear units sharing one texture memory through an arbiter
// ----------------------------------------------------------

module texture_sampler #(
	parameter int CREDITS   = 2,
	parameter int NUM_PORTS = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr_en,
	input  texel_pkg::tex_addr_t wr_addr,
	input  texel_pkg::texel_t    wr_texel,
	input  logic [NUM_PORTS-1:0] coord_valid,
	input  sampler_pkg::coord_t  coord [NUM_PORTS],
	output logic [NUM_PORTS-1:0] coord_ready,
	output logic [NUM_PORTS-1:0] sample_valid,
	output texel_pkg::sample_t   sample [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] credit_return
);
	import sampler_pkg::*;

	logic [NUM_PORTS-1:0] req_valid;
	mem_req_t             req [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant;
	logic [NUM_PORTS-1:0] rsp_valid;
	mem_rsp_t             rsp;
	logic                 mem_req_valid;
	mem_req_t             mem_req;
	mem_rsp_t             mem_rsp;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_unit
		bilinear_unit #(.CREDITS(CREDITS)) unit_i (
			.clk(clk), .reset(reset),
			.coord_valid(coord_valid[p]), .coord(coord[p]), .coord_ready(coord_ready[p]),
			.req_valid(req_valid[p]), .req(req[p]), .grant(grant[p]),
			.rsp_valid(rsp_valid[p]), .rsp(rsp),
			.sample_valid(sample_valid[p]), .sample(sample[p]),
			.credit_return(credit_return[p])
		);
	end

	texel_arbiter #(.NUM_PORTS(NUM_PORTS)) arbiter_i (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req(req), .grant(grant),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_rsp(mem_rsp)
	);

	texture_memory memory_i (
		.clk(clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_texel(wr_texel),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_rsp(mem_rsp)
	);

endmodule

//--- tests/sampler_model.svh
// ----------------------------------------------------------
// sampler reference model
// LCG for texture contents and the bilinear filter rule
// ----------------------------------------------------------
`ifndef SAMPLER_MODEL_SVH
`define SAMPLER_MODEL_SVH

function automatic logic [31:0] lcg_next(logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// taps in order 00, 10, 01, 11, so bit 0 of t is the x step
function automatic sample_t model_sample(coord_t c);
	int      sums [3];
	int      xi;
	int      yi;
	int      w;
	logic    outside;
	texel_t  tap;
	sample_t result;
	sums = '{0, 0, 0};
	result.border = 1'b1;
	for (int t = 0; t < 4; t++) begin
		// address past 31 stays at 31, still off the texture
		xi = int'(c.x_int) + t % 2;
		yi = int'(c.y_int) + t / 2;
		if (xi > 31)
			xi = 31;
		if (yi > 31)
			yi = 31;
		w = ((t % 2 == 1) ? int'(c.x_frac) : 16 - int'(c.x_frac))
			* ((t / 2 == 1) ? int'(c.y_frac) : 16 - int'(c.y_frac));
		outside = (xi >= 16) || (yi >= 16);
		if (outside)
			tap = '0;
		else
			tap = tex_mirror[xi * 16 + yi];
		result.border = result.border & outside;
		for (int k = 0; k < 3; k++)
			sums[k] += w * int'(tap[8*k +: 8]);
	end
	for (int k = 0; k < 3; k++)
		result.texel[8*k +: 8] = 8'(sums[k] >> 8);
	return result;
endfunction

`endif

//--- tests/texture_sampler_tb.sv
// ----------------------------------------------------------
// texture sampler testbench
// table-driven samples on both ports with credit control
// ----------------------------------------------------------

module texture_sampler_tb;
	import texel_pkg::*;
	import sampler_pkg::*;

	localparam int NUM_PORTS = 2;
	localparam int CREDITS   = 2;
	localparam int TIMEOUT   = 200;
	localparam int NUM_STIM  = 13;

	typedef struct {
		string  name;
		int     port;
		coord_t coord;
		bit     withhold;
	} stim_t;

	logic                 clk;
	logic                 reset;
	logic                 wr_en;
	tex_addr_t            wr_addr;
	texel_t               wr_texel;
	logic [NUM_PORTS-1:0] coord_valid;
	coord_t               coord [NUM_PORTS];
	logic [NUM_PORTS-1:0] coord_ready;
	logic [NUM_PORTS-1:0] sample_valid;
	sample_t              sample [NUM_PORTS];
	logic [NUM_PORTS-1:0] credit_return;

	texel_t  tex_mirror [256];
	sample_t exp_q [NUM_PORTS][$];
	string   name_q [NUM_PORTS][$];
	int      owed [NUM_PORTS];
	bit      hold [NUM_PORTS];

	// coordinate fields are x_int, x_frac, y_int, y_frac
	stim_t stim [NUM_STIM] = '{
		'{"zero_frac_p0", 0, '{5'd3,  4'd0,  5'd5,  4'd0},  1'b0},
		'{"zero_frac_p1", 1, '{5'd10, 4'd0,  5'd2,  4'd0},  1'b0},
		'{"frac_p0",      0, '{5'd7,  4'd5,  5'd9,  4'd11}, 1'b0},
		'{"frac_p1",      1, '{5'd0,  4'd8,  5'd14, 4'd3},  1'b0},
		'{"edge_x15",     0, '{5'd15, 4'd6,  5'd4,  4'd9},  1'b0},
		'{"outside_20",   1, '{5'd20, 4'd3,  5'd20, 4'd7},  1'b0},
		'{"edge_y15",     1, '{5'd6,  4'd0,  5'd15, 4'd12}, 1'b0},
		'{"both_p0",      0, '{5'd12, 4'd15, 5'd1,  4'd1},  1'b0},
		'{"both_p1",      1, '{5'd2,  4'd4,  5'd13, 4'd10}, 1'b0},
		'{"sat_31",       1, '{5'd31, 4'd5,  5'd3,  4'd2},  1'b0},
		'{"hold_a",       0, '{5'd4,  4'd2,  5'd6,  4'd3},  1'b1},
		'{"hold_b",       0, '{5'd8,  4'd9,  5'd8,  4'd1},  1'b1},
		'{"resume_p0",    0, '{5'd11, 4'd7,  5'd12, 4'd13}, 1'b0}
	};

	`include "sampler_model.svh"

	texture_sampler #(.CREDITS(CREDITS), .NUM_PORTS(NUM_PORTS)) dut_i (
		.clk(clk), .reset(reset),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_texel(wr_texel),
		.coord_valid(coord_valid), .coord(coord), .coord_ready(coord_ready),
		.sample_valid(sample_valid), .sample(sample), .credit_return(credit_return)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_texel(input string name, input texel_t exp, input texel_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s: texel expected %06h, actual %06h", name, exp, act));
	endtask

	task automatic check_border(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s: border expected %0b, actual %0b", name, exp, act));
	endtask

	task automatic load_texture();
		logic [31:0] state;
		state = 32'h259e9337;
		for (int a = 0; a < 256; a++) begin
			state = lcg_next(state);
			wr_en = 1'b1;
			wr_addr = tex_addr_t'(a);
			wr_texel = texel_t'(state[31:8]);
			tex_mirror[a] = texel_t'(state[31:8]);
			@(negedge clk);
		end
		wr_en = 1'b0;
	endtask

	// one handshake with the expected result queued as the coordinate goes out
	task automatic send_coord(input int p, input int i);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!coord_ready[p]) begin
			waited++;
			if (waited > TIMEOUT)
				fail_run($sformatf("timeout waiting for coord_ready on port %0d", p));
			@(negedge clk);
		end
		coord_valid[p] = 1'b1;
		coord[p] = stim[i].coord;
		exp_q[p].push_back(model_sample(stim[i].coord));
		name_q[p].push_back(stim[i].name);
		@(negedge clk);
		coord_valid[p] = 1'b0;
	endtask

	// checked on rising edges while the monitor updates on falling ones
	task automatic drain_port(input int p);
		int waited;
		waited = 0;
		@(posedge clk);
		while (exp_q[p].size() != 0 || (!hold[p] && owed[p] != 0)) begin
			waited++;
			if (waited > TIMEOUT)
				fail_run($sformatf("timeout waiting for samples on port %0d", p));
			@(posedge clk);
		end
	endtask

	task automatic expect_stall(input int p);
		repeat (8) begin
			@(negedge clk);
			if (coord_ready[p])
				fail_run($sformatf("port %0d raised coord_ready with no credits", p));
		end
		@(posedge clk);
	endtask

	task automatic drive_port(input int p);
		for (int i = 0; i < NUM_STIM; i++) begin
			if (stim[i].port == p) begin
				if (stim[i].withhold && !hold[p]) begin
					drain_port(p);
					hold[p] = 1'b1;
				end else if (!stim[i].withhold && hold[p]) begin
					drain_port(p);
					expect_stall(p);
					hold[p] = 1'b0;
				end
				send_coord(p, i);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------------------------
	// sample checker and credit return
	// ----------------------------------------------------------
	initial begin
		forever begin
			@(negedge clk);
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (sample_valid[p]) begin
					if (exp_q[p].size() == 0)
						fail_run($sformatf("unexpected sample on port %0d", p));
					check_texel(name_q[p][0], exp_q[p][0].texel, sample[p].texel);
					check_border(name_q[p][0], exp_q[p][0].border, sample[p].border);
					void'(exp_q[p].pop_front());
					void'(name_q[p].pop_front());
					owed[p]++;
				end
				credit_return[p] = !hold[p] && (owed[p] != 0);
				if (credit_return[p])
					owed[p]--;
			end
		end
	end

	initial begin
		reset = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_texel = '0;
		coord_valid = '0;
		coord[0] = '0;
		coord[1] = '0;
		credit_return = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (sample_valid !== 2'b00 || coord_ready !== 2'b11)
			fail_run("sample_valid or coord_ready wrong after reset");
		load_texture();
		fork
			drive_port(0);
			drive_port(1);
		join
		for (int p = 0; p < NUM_PORTS; p++)
			drain_port(p);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- texture_sampler.f
+incdir+tests
source/texel_pkg.sv
source/sampler_pkg.sv
source/bilinear_unit.sv
source/texel_arbiter.sv
source/texture_memory.sv
source/texture_sampler.sv
tests/texture_sampler_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = texture_sampler_tb
FILELIST  = texture_sampler.f
PASS_MSG  = TESTS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
